/* hdl/intExec_cfg.svh */
/*
 * Sizing macros for the integer execution pipeline.
 * Included by the package and by any RTL module that needs a raw width or count.
 */
`ifndef INTEXEC_CFG_SVH
`define INTEXEC_CFG_SVH

// Datapath and address width
`define INTEXEC_DATA_W     32

// Architectural register file
`define INTEXEC_REG_CNT    16
`define INTEXEC_REG_W      4

`define INTEXEC_SHAMT_W    5

// PC step past a branch or jump
`define INTEXEC_INSN_BYTES 4

`endif

/* hdl/intExecPkg.sv */
/*
 * Shared types of the integer execution pipeline.
 * Op encodings, the immediate word and the payload that travels between stages.
 */
`default_nettype none

`include "intExec_cfg.svh"

package intExecPkg;

    localparam int IMM_W = 16;

    typedef logic [`INTEXEC_DATA_W-1:0] DataPath;
    typedef logic [`INTEXEC_REG_W-1:0]  RegIdx;

    // Unit that handles the op
    typedef enum logic [2:0] {
        OP_ALU,
        OP_SHIFT,
        OP_SELECT,
        OP_BR,
        OP_JALR
    } OpType;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU
    } AluCode;

    typedef enum logic [2:0] {
        COND_EQ,
        COND_NE,
        COND_LT,
        COND_LTU,
        COND_GE,
        COND_GEU,
        COND_AL
    } CondCode;

    typedef enum logic [1:0] {
        SH_SLL,
        SH_SRL,
        SH_SRA
    } ShiftKind;

    // Shift view of the immediate, top bits unused
    typedef struct packed {
        logic [IMM_W-4-`INTEXEC_SHAMT_W:0] spare;
        logic                              immAmount;
        ShiftKind                          kind;
        logic [`INTEXEC_SHAMT_W-1:0]       amount;
    } ShiftImm;

    // Shift ops read the shift view, BR and JALR read the displacement
    typedef union packed {
        ShiftImm                 shift;
        logic signed [IMM_W-1:0] disp;
    } ImmField;

    typedef struct packed {
        OpType   opType;
        AluCode  aluCode;
        CondCode cond;
    } OpCtrl;

    typedef struct packed {
        OpCtrl   ctrl;
        RegIdx   dst;
        logic    dstWrite;
        ImmField imm;
        DataPath pc;
        logic    predTaken;
        DataPath predAddr;
        DataPath opA;
        DataPath opB;
        DataPath result;
        logic    execTaken;
        DataPath nextAddr;
        logic    mispred;
    } StagePayload;

endpackage

`default_nettype wire

/* hdl/stageIf.sv */
/*
 * One pipeline slot between two stages.
 * A slot moves when valid is high and the consumer's stall is low.
 */
`default_nettype none

interface stageIf;
    logic                    valid;
    logic                    stall;
    // Kept beside the payload for forwarding compares
    intExecPkg::RegIdx       dst;
    intExecPkg::StagePayload payload;

    modport producer (output valid, output dst, output payload, input stall);
    modport consumer (input valid, input dst, input payload, output stall);

    // Read-only tap for forwarding checks
    modport view (input valid, input dst, input payload);
endinterface

`default_nettype wire

/* hdl/regFile.sv */
/*
 * Architectural integer registers.
 * Two combinational read ports, one write port; register zero always reads zero.
 */
`default_nettype none

`include "intExec_cfg.svh"

module regFile (
    input  logic                clk,
    input  logic                arstN,
    input  intExecPkg::RegIdx   rdAddrA,
    input  intExecPkg::RegIdx   rdAddrB,
    output intExecPkg::DataPath rdDataA,
    output intExecPkg::DataPath rdDataB,
    input  logic                wrEn,
    input  intExecPkg::RegIdx   wrAddr,
    input  intExecPkg::DataPath wrData
);
    intExecPkg::DataPath regs [`INTEXEC_REG_CNT];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `INTEXEC_REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Entry zero is cleared at reset and never written
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

endmodule

`default_nettype wire

/* hdl/opIssue.sv */
/*
 * Issue stage. Accepts ops over the four-phase opReq/opAck handshake,
 * reads operands with forwarding from execute and retire, and loads the issue slot.
 */
`default_nettype none

module opIssue (
    input  logic                clk,
    input  logic                arstN,
    input  logic                opReq,
    output logic                opAck,
    input  intExecPkg::OpCtrl   opCtrl,
    input  intExecPkg::RegIdx   dst,
    input  intExecPkg::RegIdx   srcA,
    input  intExecPkg::RegIdx   srcB,
    input  logic                dstWrite,
    input  intExecPkg::ImmField imm,
    input  intExecPkg::DataPath pc,
    input  intExecPkg::DataPath predAddr,
    input  logic                predTaken,
    output intExecPkg::RegIdx   rdAddrA,
    output intExecPkg::RegIdx   rdAddrB,
    input  intExecPkg::DataPath rdDataA,
    input  intExecPkg::DataPath rdDataB,
    input  intExecPkg::DataPath exFwd,
    input  intExecPkg::DataPath rtFwd,
    stageIf.producer            outSlot,
    stageIf.view                exSlotView,
    stageIf.view                rtSlotView
);
    logic                    slotFree;
    logic                    capture;
    intExecPkg::DataPath     opA;
    intExecPkg::DataPath     opB;
    intExecPkg::StagePayload issued;

    function automatic logic slotHit(
        input logic              valid,
        input logic              wr,
        input intExecPkg::RegIdx slotDst,
        input intExecPkg::RegIdx src
    );
        return valid && wr && slotDst == src && src != '0;
    endfunction

    assign rdAddrA = srcA;
    assign rdAddrB = srcB;

    // Youngest producer wins
    always_comb begin
        if (slotHit(exSlotView.valid, exSlotView.payload.dstWrite, exSlotView.dst, srcA)) begin
            opA = exFwd;
        end else if (slotHit(rtSlotView.valid, rtSlotView.payload.dstWrite,
                             rtSlotView.dst, srcA)) begin
            opA = rtFwd;
        end else begin
            opA = rdDataA;
        end
        if (slotHit(exSlotView.valid, exSlotView.payload.dstWrite, exSlotView.dst, srcB)) begin
            opB = exFwd;
        end else if (slotHit(rtSlotView.valid, rtSlotView.payload.dstWrite,
                             rtSlotView.dst, srcB)) begin
            opB = rtFwd;
        end else begin
            opB = rdDataB;
        end
    end

    always_comb begin
        issued           = '0;
        issued.ctrl      = opCtrl;
        issued.dst       = dst;
        issued.dstWrite  = dstWrite;
        issued.imm       = imm;
        issued.pc        = pc;
        issued.predTaken = predTaken;
        issued.predAddr  = predAddr;
        issued.opA       = opA;
        issued.opB       = opB;
    end

    // Accept only when the slot is empty or leaving this cycle
    assign slotFree = !outSlot.valid || !outSlot.stall;
    assign capture  = opReq && !opAck && slotFree;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            opAck         <= 1'b0;
            outSlot.valid <= 1'b0;
        end else begin
            if (capture) begin
                opAck <= 1'b1;
            end else if (!opReq) begin
                opAck <= 1'b0;
            end
            if (capture) begin
                outSlot.valid <= 1'b1;
            end else if (!outSlot.stall) begin
                outSlot.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            outSlot.dst     <= dst;
            outSlot.payload <= issued;
        end
    end

    // Source holds the request and the op fields until the acknowledge
    reqHeld: assert property (@(posedge clk) disable iff (!arstN)
        opReq && !opAck |=> opAck
            || (opReq && $stable({opCtrl, dst, srcA, srcB, dstWrite, imm, pc, predAddr,
                                  predTaken})))
        else $error("opReq dropped or op fields changed before opAck");

endmodule

`default_nettype wire

/* hdl/intExecStage.sv */
/*
 * Execute stage. ALU, shifter, select, branch and JALR resolution on the issue slot,
 * registered into the slot toward retire. exFwd exposes the result for forwarding.
 */
`default_nettype none

`include "intExec_cfg.svh"

module intExecStage (
    input  logic                clk,
    input  logic                arstN,
    stageIf.consumer            inSlot,
    stageIf.producer            outSlot,
    output intExecPkg::DataPath exFwd
);
    intExecPkg::StagePayload     pl;
    intExecPkg::StagePayload     exOut;
    logic                        condTrue;
    intExecPkg::DataPath         aluOut;
    logic [`INTEXEC_SHAMT_W-1:0] shAmt;
    intExecPkg::DataPath         shOut;
    intExecPkg::DataPath         disp;
    intExecPkg::DataPath         linkAddr;
    intExecPkg::DataPath         jalrTarget;
    logic                        isBranch;
    logic                        advance;

    function automatic logic condHolds(
        input intExecPkg::CondCode cond,
        input intExecPkg::DataPath a,
        input intExecPkg::DataPath b
    );
        logic holds;
        case (cond)
            intExecPkg::COND_EQ:  holds = (a == b);
            intExecPkg::COND_NE:  holds = (a != b);
            intExecPkg::COND_LT:  holds = ($signed(a) < $signed(b));
            intExecPkg::COND_LTU: holds = (a < b);
            intExecPkg::COND_GE:  holds = ($signed(a) >= $signed(b));
            intExecPkg::COND_GEU: holds = (a >= b);
            default:              holds = 1'b1;
        endcase
        return holds;
    endfunction

    always_comb begin
        pl       = inSlot.payload;
        condTrue = condHolds(pl.ctrl.cond, pl.opA, pl.opB);

        case (pl.ctrl.aluCode)
            intExecPkg::ALU_SUB:  aluOut = pl.opA - pl.opB;
            intExecPkg::ALU_AND:  aluOut = pl.opA & pl.opB;
            intExecPkg::ALU_OR:   aluOut = pl.opA | pl.opB;
            intExecPkg::ALU_XOR:  aluOut = pl.opA ^ pl.opB;
            intExecPkg::ALU_SLT:  aluOut = intExecPkg::DataPath'($signed(pl.opA) < $signed(pl.opB));
            intExecPkg::ALU_SLTU: aluOut = intExecPkg::DataPath'(pl.opA < pl.opB);
            default:              aluOut = pl.opA + pl.opB;
        endcase

        // Amount from the immediate view or from operand B
        shAmt = pl.imm.shift.immAmount ? pl.imm.shift.amount : pl.opB[`INTEXEC_SHAMT_W-1:0];
        case (pl.imm.shift.kind)
            intExecPkg::SH_SLL: shOut = pl.opA << shAmt;
            intExecPkg::SH_SRL: shOut = pl.opA >> shAmt;
            intExecPkg::SH_SRA: shOut = $signed(pl.opA) >>> shAmt;
            default:            shOut = pl.opA;
        endcase

        disp = {{(`INTEXEC_DATA_W-intExecPkg::IMM_W){pl.imm.disp[intExecPkg::IMM_W-1]}},
                pl.imm.disp};
        linkAddr   = pl.pc + `INTEXEC_DATA_W'(`INTEXEC_INSN_BYTES);
        jalrTarget = pl.opA + disp;
        jalrTarget[0] = 1'b0;
        isBranch   = pl.ctrl.opType inside {intExecPkg::OP_BR, intExecPkg::OP_JALR};

        exOut = pl;
        exOut.execTaken = (pl.ctrl.opType == intExecPkg::OP_JALR)
                       || (pl.ctrl.opType == intExecPkg::OP_BR && condTrue);
        if (pl.ctrl.opType == intExecPkg::OP_JALR) begin
            exOut.nextAddr = jalrTarget;
        end else if (exOut.execTaken) begin
            exOut.nextAddr = pl.pc + disp;
        end else begin
            exOut.nextAddr = linkAddr;
        end

        // Wrong direction, or taken to the wrong place
        exOut.mispred = isBranch && ((pl.predTaken != exOut.execTaken)
                     || (exOut.execTaken && pl.predAddr != exOut.nextAddr));

        case (pl.ctrl.opType)
            intExecPkg::OP_SHIFT:  exOut.result = shOut;
            intExecPkg::OP_SELECT: exOut.result = condTrue ? pl.opA : pl.opB;
            intExecPkg::OP_BR,
            intExecPkg::OP_JALR:   exOut.result = linkAddr;
            default:               exOut.result = aluOut;
        endcase
    end

    assign exFwd = exOut.result;

    // Hold while retire is still busy with an earlier result
    assign advance      = !outSlot.valid || !outSlot.stall;
    assign inSlot.stall = !advance;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outSlot.valid <= 1'b0;
        end else if (advance) begin
            outSlot.valid <= inSlot.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && inSlot.valid) begin
            outSlot.dst     <= inSlot.dst;
            outSlot.payload <= exOut;
        end
    end

    // Shift ops carry one of the three defined kinds
    shiftKindLegal: assert property (@(posedge clk) disable iff (!arstN)
        inSlot.valid && inSlot.payload.ctrl.opType == intExecPkg::OP_SHIFT
        |-> inSlot.payload.imm.shift.kind != 2'b11)
        else $error("shift op with an undefined shift kind");

endmodule

`default_nettype wire

/* hdl/resultRetire.sv */
/*
 * Retire stage. Writes the register file when a result enters,
 * then presents it over the four-phase resReq/resAck handshake.
 */
`default_nettype none

module resultRetire (
    input  logic                clk,
    input  logic                arstN,
    stageIf.consumer            inSlot,
    output intExecPkg::DataPath rtFwd,
    output logic                wrEn,
    output intExecPkg::RegIdx   wrAddr,
    output intExecPkg::DataPath wrData,
    output logic                resReq,
    input  logic                resAck,
    output intExecPkg::DataPath resData,
    output intExecPkg::RegIdx   resDst,
    output logic                resWrite,
    output logic                brValid,
    output logic                brTaken,
    output intExecPkg::DataPath brNextAddr,
    output logic                brMispred
);
    logic                    busy;
    logic                    entry;
    intExecPkg::StagePayload held;

    // Busy until the sink has dropped its acknowledge
    assign busy         = resReq || resAck;
    assign entry        = inSlot.valid && !busy;
    assign inSlot.stall = busy;

    // Result waiting to enter, still missing from the register file
    assign rtFwd = inSlot.payload.result;

    // Write happens on the entry edge
    assign wrEn   = entry && inSlot.payload.dstWrite;
    assign wrAddr = inSlot.dst;
    assign wrData = inSlot.payload.result;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resReq <= 1'b0;
        end else if (entry) begin
            resReq <= 1'b1;
        end else if (resAck) begin
            resReq <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (entry) begin
            held <= inSlot.payload;
        end
    end

    assign resData    = held.result;
    assign resDst     = held.dst;
    assign resWrite   = held.dstWrite;
    assign brValid    = held.ctrl.opType inside {intExecPkg::OP_BR, intExecPkg::OP_JALR};
    assign brTaken    = held.execTaken;
    assign brNextAddr = held.nextAddr;
    assign brMispred  = held.mispred;

    // Sink acknowledges only a pending request
    ackOnReq: assert property (@(posedge clk) disable iff (!arstN)
        $rose(resAck) |-> resReq)
        else $error("resAck rose while resReq was low");

endmodule

`default_nettype wire

/* hdl/intExecTop.sv */
/*
 * Top of the integer execution pipeline.
 * Plain handshake ports; connects issue, execute, retire and the register file.
 */
`default_nettype none

module intExecTop (
    input  logic                clk,
    input  logic                arstN,
    input  logic                opReq,
    output logic                opAck,
    input  intExecPkg::OpCtrl   opCtrl,
    input  intExecPkg::RegIdx   dst,
    input  intExecPkg::RegIdx   srcA,
    input  intExecPkg::RegIdx   srcB,
    input  logic                dstWrite,
    input  intExecPkg::ImmField imm,
    input  intExecPkg::DataPath pc,
    input  intExecPkg::DataPath predAddr,
    input  logic                predTaken,
    output logic                resReq,
    input  logic                resAck,
    output intExecPkg::DataPath resData,
    output intExecPkg::RegIdx   resDst,
    output logic                resWrite,
    output logic                brValid,
    output logic                brTaken,
    output intExecPkg::DataPath brNextAddr,
    output logic                brMispred
);
    intExecPkg::RegIdx   rdAddrA;
    intExecPkg::RegIdx   rdAddrB;
    intExecPkg::DataPath rdDataA;
    intExecPkg::DataPath rdDataB;
    intExecPkg::DataPath exFwd;
    intExecPkg::DataPath rtFwd;
    logic                wrEn;
    intExecPkg::RegIdx   wrAddr;
    intExecPkg::DataPath wrData;

    stageIf issueToExec ();
    stageIf execToRetire ();

    regFile u_regFile (
        .clk(clk), .arstN(arstN),
        .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdDataA(rdDataA), .rdDataB(rdDataB),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
    );

    opIssue u_opIssue (
        .clk(clk), .arstN(arstN), .opReq(opReq), .opAck(opAck),
        .opCtrl(opCtrl), .dst(dst), .srcA(srcA), .srcB(srcB), .dstWrite(dstWrite),
        .imm(imm), .pc(pc), .predAddr(predAddr), .predTaken(predTaken),
        .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdDataA(rdDataA), .rdDataB(rdDataB),
        .exFwd(exFwd), .rtFwd(rtFwd),
        .outSlot(issueToExec.producer),
        .exSlotView(issueToExec.view),
        .rtSlotView(execToRetire.view)
    );

    intExecStage u_intExecStage (
        .clk(clk), .arstN(arstN),
        .inSlot(issueToExec.consumer),
        .outSlot(execToRetire.producer),
        .exFwd(exFwd)
    );

    resultRetire u_resultRetire (
        .clk(clk), .arstN(arstN),
        .inSlot(execToRetire.consumer),
        .rtFwd(rtFwd), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .resReq(resReq), .resAck(resAck),
        .resData(resData), .resDst(resDst), .resWrite(resWrite),
        .brValid(brValid), .brTaken(brTaken), .brNextAddr(brNextAddr), .brMispred(brMispred)
    );

endmodule

`default_nettype wire

/* dv/intExecTb.sv */
/*
 * Testbench for the integer execution pipeline.
 * Issues directed and random ops over opReq/opAck, acknowledges results after a
 * random delay and checks each result against a reference model with assertions.
 */
`default_nettype none

`include "intExec_cfg.svh"

module intExecTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 200;
    localparam int MAX_OPS = 1024;

    // Expected outcome of one op, in issue order
    typedef struct packed {
        intExecPkg::DataPath result;
        intExecPkg::RegIdx   dst;
        logic                wr;
        logic                brValid;
        logic                taken;
        intExecPkg::DataPath next;
        logic                mispred;
    } ExpRec;

    logic                clk = 1'b0;
    logic                arstN;
    logic                opReq;
    logic                opAck;
    intExecPkg::OpCtrl   opCtrl;
    intExecPkg::RegIdx   dst;
    intExecPkg::RegIdx   srcA;
    intExecPkg::RegIdx   srcB;
    logic                dstWrite;
    intExecPkg::ImmField imm;
    intExecPkg::DataPath pc;
    intExecPkg::DataPath predAddr;
    logic                predTaken;
    logic                resReq;
    logic                resAck;
    intExecPkg::DataPath resData;
    intExecPkg::RegIdx   resDst;
    logic                resWrite;
    logic                brValid;
    logic                brTaken;
    intExecPkg::DataPath brNextAddr;
    logic                brMispred;

    intExecPkg::DataPath refRegs [`INTEXEC_REG_CNT];
    ExpRec               expList [MAX_OPS];
    int                  issueCount;
    int                  resCount;
    int                  mismatchCount;
    int                  timeoutCount;
    int                  otherCount;
    int                  maxAckDelay;
    integer              seed = 84187;
    logic                srcDone;
    logic                abort;

    intExecTop u_dut (.*);

    always #5 clk = ~clk;

    // Result checks, taken on the edge where resReq rises
    resDataCheck: assert property (@(posedge clk) disable iff (!arstN)
        $rose(resReq) |-> resData == expList[resCount].result)
        else begin
            mismatchCount++;
            $display("mismatch resData: got %h expected %h", resData, expList[resCount].result);
        end

    resDstCheck: assert property (@(posedge clk) disable iff (!arstN)
        $rose(resReq) |-> resDst == expList[resCount].dst)
        else begin
            mismatchCount++;
            $display("mismatch resDst: got %h expected %h", resDst, expList[resCount].dst);
        end

    resWriteCheck: assert property (@(posedge clk) disable iff (!arstN)
        $rose(resReq) |-> resWrite == expList[resCount].wr)
        else begin
            mismatchCount++;
            $display("mismatch resWrite: got %h expected %h", resWrite, expList[resCount].wr);
        end

    brValidCheck: assert property (@(posedge clk) disable iff (!arstN)
        $rose(resReq) |-> brValid == expList[resCount].brValid)
        else begin
            mismatchCount++;
            $display("mismatch brValid: got %h expected %h", brValid, expList[resCount].brValid);
        end

    brTakenCheck: assert property (@(posedge clk) disable iff (!arstN)
        $rose(resReq) |-> brTaken == expList[resCount].taken)
        else begin
            mismatchCount++;
            $display("mismatch brTaken: got %h expected %h", brTaken, expList[resCount].taken);
        end

    brMispredCheck: assert property (@(posedge clk) disable iff (!arstN)
        $rose(resReq) |-> brMispred == expList[resCount].mispred)
        else begin
            mismatchCount++;
            $display("mismatch brMispred: got %h expected %h",
                     brMispred, expList[resCount].mispred);
        end

    // Next address only means something for branches and jumps
    brNextCheck: assert property (@(posedge clk) disable iff (!arstN)
        $rose(resReq) && expList[resCount].brValid |-> brNextAddr == expList[resCount].next)
        else begin
            mismatchCount++;
            $display("mismatch brNextAddr: got %h expected %h",
                     brNextAddr, expList[resCount].next);
        end

    noSpuriousResult: assert property (@(posedge clk) disable iff (!arstN)
        $rose(resReq) |-> resCount < issueCount)
        else begin
            otherCount++;
            $display("result presented with no op outstanding");
        end

    resHeld: assert property (@(posedge clk) disable iff (!arstN)
        resReq && $past(resReq)
        |-> $stable({resData, resDst, resWrite, brValid, brTaken, brNextAddr, brMispred}))
        else begin
            otherCount++;
            $display("result fields changed while resReq was high");
        end

    function automatic logic condMet(
        input intExecPkg::CondCode c,
        input intExecPkg::DataPath a,
        input intExecPkg::DataPath b
    );
        case (c)
            intExecPkg::COND_EQ:  return a == b;
            intExecPkg::COND_NE:  return a != b;
            intExecPkg::COND_LT:  return $signed(a) < $signed(b);
            intExecPkg::COND_LTU: return a < b;
            intExecPkg::COND_GE:  return $signed(a) >= $signed(b);
            intExecPkg::COND_GEU: return a >= b;
            default:              return 1'b1;
        endcase
    endfunction

    // Reference model of the execute rules
    function automatic ExpRec predictOutcome(
        input intExecPkg::OpCtrl   ctrl,
        input intExecPkg::ImmField im,
        input intExecPkg::DataPath p,
        input intExecPkg::DataPath a,
        input intExecPkg::DataPath b,
        input logic                pt,
        input intExecPkg::DataPath pa
    );
        ExpRec               rec;
        intExecPkg::DataPath offset;
        intExecPkg::DataPath link;
        logic [4:0]          amt;
        logic                hit;
        rec    = '0;
        offset = {{(`INTEXEC_DATA_W - intExecPkg::IMM_W){im.disp[intExecPkg::IMM_W-1]}}, im.disp};
        link   = p + `INTEXEC_INSN_BYTES;
        hit    = condMet(ctrl.cond, a, b);
        amt    = im.shift.immAmount ? im.shift.amount : b[4:0];
        case (ctrl.opType)
            intExecPkg::OP_ALU: begin
                case (ctrl.aluCode)
                    intExecPkg::ALU_ADD:  rec.result = a + b;
                    intExecPkg::ALU_SUB:  rec.result = a - b;
                    intExecPkg::ALU_AND:  rec.result = a & b;
                    intExecPkg::ALU_OR:   rec.result = a | b;
                    intExecPkg::ALU_XOR:  rec.result = a ^ b;
                    intExecPkg::ALU_SLT:  rec.result = ($signed(a) < $signed(b)) ? 1 : 0;
                    intExecPkg::ALU_SLTU: rec.result = (a < b) ? 1 : 0;
                    default:              rec.result = '0;
                endcase
            end
            intExecPkg::OP_SHIFT: begin
                case (im.shift.kind)
                    intExecPkg::SH_SLL: rec.result = a << amt;
                    intExecPkg::SH_SRL: rec.result = a >> amt;
                    default:            rec.result = $signed(a) >>> amt;
                endcase
            end
            intExecPkg::OP_SELECT: rec.result = hit ? a : b;
            intExecPkg::OP_BR: begin
                rec.brValid = 1'b1;
                rec.taken   = hit;
                rec.next    = hit ? p + offset : link;
                rec.result  = link;
            end
            default: begin
                rec.brValid = 1'b1;
                rec.taken   = 1'b1;
                rec.next    = a + offset;
                rec.next[0] = 1'b0;
                rec.result  = link;
            end
        endcase
        rec.mispred = rec.brValid && (pt != rec.taken || (rec.taken && pa != rec.next));
        return rec;
    endfunction

    function automatic intExecPkg::RegIdx randReg();
        return 4'($random(seed));
    endfunction

    // One op through the four-phase source handshake; called on a falling edge
    task automatic sendOp(
        input intExecPkg::OpType t,
        input logic [2:0]        code,
        input intExecPkg::RegIdx d,
        input intExecPkg::RegIdx sa,
        input intExecPkg::RegIdx sb,
        input logic              wr
    );
        intExecPkg::OpCtrl   ctrl;
        intExecPkg::ImmField im;
        intExecPkg::DataPath p;
        intExecPkg::DataPath pa;
        logic                pt;
        ExpRec               rec;
        int                  cnt;
        if (abort) begin
            return;
        end
        ctrl.opType  = t;
        ctrl.aluCode = intExecPkg::AluCode'(code);
        ctrl.cond    = intExecPkg::CondCode'(code);
        im = 16'($random(seed));
        if (t == intExecPkg::OP_SHIFT) begin
            im.shift.immAmount = code[2];
            im.shift.kind      = intExecPkg::ShiftKind'(code[1:0]);
        end
        p      = $random(seed);
        p[1:0] = 2'b00;
        pt     = 1'($random(seed));
        // Half the predictions aim at the real target
        rec = predictOutcome(ctrl, im, p, refRegs[sa], refRegs[sb], pt, '0);
        if ($random(seed) & 1) begin
            pa = rec.next;
        end else begin
            pa = $random(seed);
        end
        rec     = predictOutcome(ctrl, im, p, refRegs[sa], refRegs[sb], pt, pa);
        rec.dst = d;
        rec.wr  = wr;
        if (wr && d != '0) begin
            refRegs[d] = rec.result;
        end
        expList[issueCount] = rec;

        opCtrl    = ctrl;
        dst       = d;
        srcA      = sa;
        srcB      = sb;
        dstWrite  = wr;
        imm       = im;
        pc        = p;
        predAddr  = pa;
        predTaken = pt;
        opReq     = 1'b1;
        cnt = 0;
        while (!opAck && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!opAck) begin
            timeoutCount++;
            abort = 1'b1;
            $display("timeout waiting for opAck on op %0d", issueCount);
            return;
        end
        issueCount++;
        opReq = 1'b0;
        cnt = 0;
        while (opAck && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (opAck) begin
            timeoutCount++;
            abort = 1'b1;
            $display("timeout waiting for opAck to fall after op %0d", issueCount - 1);
        end
    endtask

    task automatic runSource();
        intExecPkg::OpType t;
        logic [2:0]        code;
        intExecPkg::RegIdx prev;
        intExecPkg::RegIdx s;
        // Link results give every register a distinct value
        for (int r = 1; r < `INTEXEC_REG_CNT; r++) begin
            sendOp(intExecPkg::OP_BR, 3'(intExecPkg::COND_AL), 4'(r), 4'd0, 4'd0, 1'b1);
        end
        for (int c = 0; c < 7; c++) begin
            repeat (4) sendOp(intExecPkg::OP_ALU, 3'(c), randReg(), randReg(), randReg(), 1'b1);
        end
        // Bit 2 selects the immediate amount, bits 1:0 the kind
        for (int c = 0; c < 8; c++) begin
            if (c % 4 != 3) begin
                repeat (4) sendOp(intExecPkg::OP_SHIFT, 3'(c), randReg(), randReg(), randReg(),
                                  1'b1);
            end
        end
        // Dependent chain, slow sink forces forwarding from the issue slot too
        maxAckDelay = 2;
        prev = 4'd1;
        for (int i = 0; i < 30; i++) begin
            code = (i % 2 != 0) ? 3'(intExecPkg::ALU_XOR) : 3'(intExecPkg::ALU_ADD);
            sendOp(intExecPkg::OP_ALU, code, 4'(1 + i % 3), prev, 4'(1 + (i + 2) % 3), 1'b1);
            prev = 4'(1 + i % 3);
        end
        maxAckDelay = 1;
        for (int c = 0; c < 7; c++) begin
            repeat (3) sendOp(intExecPkg::OP_SELECT, 3'(c), randReg(), randReg(), randReg(),
                              1'b1);
            repeat (3) sendOp(intExecPkg::OP_BR, 3'(c), randReg(), randReg(), randReg(), 1'b1);
            s = randReg();
            sendOp(intExecPkg::OP_BR, 3'(c), randReg(), s, s, 1'b1);
        end
        repeat (8) sendOp(intExecPkg::OP_JALR, 3'd0, randReg(), randReg(), randReg(), 1'b1);
        // Register zero ignores the write
        sendOp(intExecPkg::OP_ALU, 3'(intExecPkg::ALU_ADD), 4'd0, 4'd3, 4'd4, 1'b1);
        sendOp(intExecPkg::OP_ALU, 3'(intExecPkg::ALU_OR), 4'd5, 4'd0, 4'd0, 1'b1);
        maxAckDelay = 3;
        repeat (300) begin
            t    = intExecPkg::OpType'($unsigned($random(seed)) % 5);
            code = 3'($unsigned($random(seed)) % 7);
            if (t == intExecPkg::OP_SHIFT && code[1:0] == 2'd3) begin
                code[1:0] = 2'd0;
            end
            sendOp(t, code, randReg(), randReg(), randReg(), ($random(seed) & 7) != 0);
        end
        srcDone = 1'b1;
    endtask

    // Four-phase sink with a random delay before each acknowledge
    task automatic runSink();
        int cnt;
        int delay;
        while (!abort && !(srcDone && resCount == issueCount)) begin
            cnt = 0;
            while (!resReq && !abort && !(srcDone && resCount == issueCount) && cnt < TIMEOUT) begin
                @(negedge clk);
                cnt++;
            end
            if (resReq) begin
                delay = $unsigned($random(seed)) % (maxAckDelay + 1);
                repeat (delay) @(negedge clk);
                resAck = 1'b1;
                cnt = 0;
                while (resReq && cnt < TIMEOUT) begin
                    @(negedge clk);
                    cnt++;
                end
                if (resReq) begin
                    timeoutCount++;
                    abort = 1'b1;
                    $display("timeout waiting for resReq to fall on result %0d", resCount);
                end
                resAck = 1'b0;
                resCount++;
            end else if (cnt >= TIMEOUT) begin
                timeoutCount++;
                abort = 1'b1;
                $display("timeout waiting for result %0d", resCount);
            end
        end
    endtask

    initial begin
        arstN         = 1'b0;
        opReq         = 1'b0;
        opCtrl        = '0;
        dst           = '0;
        srcA          = '0;
        srcB          = '0;
        dstWrite      = 1'b0;
        imm           = '0;
        pc            = '0;
        predAddr      = '0;
        predTaken     = 1'b0;
        resAck        = 1'b0;
        issueCount    = 0;
        resCount      = 0;
        mismatchCount = 0;
        timeoutCount  = 0;
        otherCount    = 0;
        maxAckDelay   = 0;
        srcDone       = 1'b0;
        abort         = 1'b0;
        for (int r = 0; r < `INTEXEC_REG_CNT; r++) begin
            refRegs[r] = '0;
        end
        repeat (2) @(negedge clk);
        arstN = 1'b1;
        // Idle after reset, nothing requested yet
        repeat (3) @(negedge clk);
        idleAfterReset: assert (!opAck && !resReq)
            else begin
                otherCount++;
                $display("opAck or resReq high with no request pending");
            end
        fork
            runSource();
            runSink();
        join
        if (resCount != issueCount) begin
            otherCount++;
            $display("%0d ops issued but %0d results received", issueCount, resCount);
        end
        $display("errors: %0d mismatches, %0d timeouts, %0d other",
                 mismatchCount, timeoutCount, otherCount);
        if (mismatchCount + timeoutCount + otherCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hdl
hdl/intExecPkg.sv
hdl/stageIf.sv
hdl/regFile.sv
hdl/opIssue.sv
hdl/intExecStage.sv
hdl/resultRetire.sv
hdl/intExecTop.sv
dv/intExecTb.sv
